/* source/ddr_lane_pkg.sv */
//////////////////////////////////////////////////
// DFI-side lane geometry, widths and the write
// calibration pattern replicated across lanes
//////////////////////////////////////////////////
`default_nettype none

package ddr_lane_pkg;

    localparam int LANES      = 2;
    localparam int PHASES     = 4;
    localparam int LANE_DLY_W = 9;
    localparam int MOVE_BIT   = 8;
    localparam int CAL_WORD_W = LANES * 64;

    localparam logic [63:0] WRCAL_PATTERN = 64'h6644_99FF_AACC_3355;

    typedef logic [CAL_WORD_W-1:0] cal_word_t;

    // Byte-major layout with the same byte in every lane
    function automatic cal_word_t lane_replicate(input logic [63:0] pat);
        cal_word_t word;
        for (int b = 0; b < 8; b++) begin
            for (int l = 0; l < LANES; l++) begin
                word[(b*LANES + l)*8 +: 8] = pat[b*8 +: 8];
            end
        end
        return word;
    endfunction

    localparam cal_word_t WRCAL_WORD = lane_replicate(WRCAL_PATTERN);

endpackage

`default_nettype wire

/* source/trn_seq_pkg.sv */
//////////////////////////////////////////////////
// Training FSM states and sequencing counts
//////////////////////////////////////////////////
`default_nettype none

package trn_seq_pkg;

    typedef enum logic [7:0] {
        IDLE,
        CLK_ROTATE_SEL,
        CLK_ROTATE_WAIT,
        CLK_ROTATE,
        CLK_ROTATE_WAIT_2,
        CMD_RESET,
        WAIT_HOLD_INIT,
        PHY_INIT_COMPLETE,
        WAIT_CTRL_READY,
        WRITE_MOVE_START,
        WRITE_MOVE,
        WRITE_MOVE_PULSE,
        GATE_START,
        GATE_READ_REQ,
        GATE_WAIT_RDEN,
        GATE_WAIT_BURST,
        GATE_NEXT_PHASE,
        WRCAL_START,
        WRCAL_W_REQ,
        WRCAL_D_REQ,
        WRCAL_WAIT_BUSY,
        WRCAL_READ_REQ,
        WRCAL_WAIT_VAL,
        WRCAL_CHECK,
        WRCAL_INCR,
        DONE,
        FINISHED
    } trn_state_t;

    localparam int CLK_ROTATE_STEPS  = 8;
    localparam int HOLD_INIT_CYCLES  = 50;
    localparam int WRITE_MOVE_PULSES = 10;
    localparam int GATE_WAIT_LIMIT   = 64;

    localparam int PHASE_SEL_W     = 3;
    localparam int WRCAL_OFFSET_W  = 3;
    localparam int VCOPHS_OFFSET_W = 3;

    // Search starts from the latest read-enable phase
    localparam logic [PHASE_SEL_W-1:0] GATE_PHASE_INIT = 3'd7;

endpackage

`default_nettype wire

/* source/trn_sequencer.sv */
//////////////////////////////////////////////////
// Training FSM with registered PLL, lane, DFI and
// calibration port controls
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module trn_sequencer (
    input  wire                                       SCLK,
    input  wire                                       INIT_RESET_int,
    input  wire  [trn_seq_pkg::VCOPHS_OFFSET_W-1:0]   addr_vcophs_offset,
    input  wire                                       ctrlr_ready_in,
    input  wire                                       rden_p0_seen,
    input  wire                                       gate_good_burst,
    input  wire                                       wrcal_match,
    input  wire                                       cal_l_d_req,
    input  wire                                       cal_l_busy,
    input  wire                                       cal_l_r_valid,
    output logic                                      loadphs_b,
    output logic                                      vco_phsel_bclk_sel,
    output logic                                      vco_phsel_bclk90_sel,
    output logic                                      vco_phsel_refclk_sel,
    output logic                                      vco_phsel_rotate,
    output logic [ddr_lane_pkg::LANES*ddr_lane_pkg::LANE_DLY_W-1:0] move,
    output logic [ddr_lane_pkg::LANES-1:0]            delay_line_sel_rd,
    output logic [ddr_lane_pkg::LANES-1:0]            init_pause,
    output logic                                      cmd_reset_lane,
    output logic                                      dfi_init_complete,
    output logic                                      dfi_training_complete,
    output logic                                      ctrlr_ready_out,
    output logic                                      cal_select,
    output logic                                      cal_l_r_req,
    output logic                                      cal_l_w_req,
    output ddr_lane_pkg::cal_word_t                   cal_l_datain,
    output logic [trn_seq_pkg::PHASE_SEL_W-1:0]       gate_phase_sel,
    output logic [trn_seq_pkg::WRCAL_OFFSET_W-1:0]    write_cal_offset
);

    import ddr_lane_pkg::*;
    import trn_seq_pkg::*;

    trn_state_t state;
    trn_state_t state_nxt;

    // Shared by rotation, hold, walk and gate timeout
    logic [$clog2(GATE_WAIT_LIMIT)-1:0] step_cnt;

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:              state_nxt = CLK_ROTATE_SEL;
            CLK_ROTATE_SEL:    state_nxt = CLK_ROTATE_WAIT;
            CLK_ROTATE_WAIT:   state_nxt = CLK_ROTATE;
            CLK_ROTATE:        state_nxt = CLK_ROTATE_WAIT_2;
            CLK_ROTATE_WAIT_2: begin
                if (step_cnt == CLK_ROTATE_STEPS) begin
                    state_nxt = CMD_RESET;
                end else begin
                    state_nxt = CLK_ROTATE_SEL;
                end
            end
            CMD_RESET:         state_nxt = WAIT_HOLD_INIT;
            WAIT_HOLD_INIT: begin
                if (step_cnt == HOLD_INIT_CYCLES - 1) begin
                    state_nxt = PHY_INIT_COMPLETE;
                end
            end
            PHY_INIT_COMPLETE: state_nxt = WAIT_CTRL_READY;
            WAIT_CTRL_READY: begin
                if (ctrlr_ready_in) begin
                    state_nxt = WRITE_MOVE_START;
                end
            end
            WRITE_MOVE_START:  state_nxt = WRITE_MOVE;
            WRITE_MOVE: begin
                if (step_cnt == WRITE_MOVE_PULSES) begin
                    state_nxt = GATE_START;
                end else begin
                    state_nxt = WRITE_MOVE_PULSE;
                end
            end
            WRITE_MOVE_PULSE:  state_nxt = WRITE_MOVE;
            GATE_START:        state_nxt = GATE_READ_REQ;
            GATE_READ_REQ:     state_nxt = GATE_WAIT_RDEN;
            GATE_WAIT_RDEN: begin
                if (rden_p0_seen) begin
                    state_nxt = GATE_WAIT_BURST;
                end
            end
            GATE_WAIT_BURST: begin
                if (gate_good_burst) begin
                    state_nxt = WRCAL_START;
                end else if (step_cnt == GATE_WAIT_LIMIT - 1) begin
                    state_nxt = GATE_NEXT_PHASE;
                end
            end
            GATE_NEXT_PHASE:   state_nxt = GATE_READ_REQ;
            WRCAL_START:       state_nxt = WRCAL_W_REQ;
            WRCAL_W_REQ:       state_nxt = WRCAL_D_REQ;
            WRCAL_D_REQ: begin
                if (cal_l_d_req) begin
                    state_nxt = WRCAL_WAIT_BUSY;
                end
            end
            WRCAL_WAIT_BUSY: begin
                if (!cal_l_busy) begin
                    state_nxt = WRCAL_READ_REQ;
                end
            end
            WRCAL_READ_REQ:    state_nxt = WRCAL_WAIT_VAL;
            WRCAL_WAIT_VAL: begin
                if (cal_l_r_valid) begin
                    state_nxt = WRCAL_CHECK;
                end
            end
            WRCAL_CHECK:       state_nxt = wrcal_match ? DONE : WRCAL_INCR;
            WRCAL_INCR:        state_nxt = WRCAL_W_REQ;
            DONE:              state_nxt = FINISHED;
            FINISHED:          state_nxt = FINISHED;
            default:           state_nxt = IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // State, counter and registered outputs
    //////////////////////////////////////////////////
    always_ff @(posedge SCLK or negedge INIT_RESET_int) begin
        if (!INIT_RESET_int) begin
            state                 <= IDLE;
            step_cnt              <= '0;
            loadphs_b             <= 1'b0;
            vco_phsel_bclk_sel    <= 1'b0;
            vco_phsel_bclk90_sel  <= 1'b0;
            vco_phsel_refclk_sel  <= 1'b0;
            vco_phsel_rotate      <= 1'b0;
            move                  <= '0;
            delay_line_sel_rd     <= '1;
            init_pause            <= '0;
            cmd_reset_lane        <= 1'b0;
            dfi_init_complete     <= 1'b0;
            dfi_training_complete <= 1'b0;
            ctrlr_ready_out       <= 1'b0;
            cal_select            <= 1'b0;
            cal_l_r_req           <= 1'b0;
            cal_l_w_req           <= 1'b0;
            gate_phase_sel        <= GATE_PHASE_INIT;
            write_cal_offset      <= '0;
        end else begin
            state <= state_nxt;

            // Pulse outputs last one cycle
            loadphs_b        <= 1'b0;
            vco_phsel_rotate <= 1'b0;
            move             <= '0;
            init_pause       <= '0;
            cmd_reset_lane   <= 1'b0;
            cal_l_r_req      <= 1'b0;
            cal_l_w_req      <= 1'b0;

            case (state)
                IDLE: begin
                    step_cnt  <= '0;
                    loadphs_b <= 1'b1;
                end
                CLK_ROTATE_SEL: begin
                    // REFCLK lands 180 deg of BCLK, BCLK 90 deg of SCLK
                    vco_phsel_refclk_sel <= (step_cnt <= addr_vcophs_offset + 1);
                    vco_phsel_bclk90_sel <= (step_cnt <= 3);
                    vco_phsel_bclk_sel   <= (step_cnt <= 1);
                    if (step_cnt <= 1) begin
                        move <= {LANES{LANE_DLY_W'(1 << MOVE_BIT)}};
                    end
                end
                CLK_ROTATE: begin
                    vco_phsel_rotate <= 1'b1;
                    step_cnt         <= step_cnt + 1'b1;
                end
                CMD_RESET: begin
                    cmd_reset_lane <= 1'b1;
                    step_cnt       <= '0;
                end
                WAIT_HOLD_INIT:    step_cnt <= step_cnt + 1'b1;
                PHY_INIT_COMPLETE: dfi_init_complete <= 1'b1;
                WRITE_MOVE_START: begin
                    delay_line_sel_rd <= '0;
                    step_cnt          <= '0;
                end
                WRITE_MOVE_PULSE: begin
                    move     <= {LANES{LANE_DLY_W'(1 << MOVE_BIT)}};
                    step_cnt <= step_cnt + 1'b1;
                end
                GATE_START: begin
                    init_pause <= '1;
                    cal_select <= 1'b1;
                end
                GATE_READ_REQ: begin
                    cal_l_r_req <= 1'b1;
                    step_cnt    <= '0;
                end
                GATE_WAIT_BURST:   step_cnt <= step_cnt + 1'b1;
                GATE_NEXT_PHASE: begin
                    // Walk earlier so the preamble is never latched
                    gate_phase_sel <= gate_phase_sel - 1'b1;
                    init_pause     <= '1;
                end
                WRCAL_W_REQ:       cal_l_w_req <= 1'b1;
                WRCAL_READ_REQ:    cal_l_r_req <= 1'b1;
                WRCAL_INCR:        write_cal_offset <= write_cal_offset + 1'b1;
                DONE: begin
                    dfi_training_complete <= 1'b1;
                    ctrlr_ready_out       <= 1'b1;
                    cal_select            <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    // Calibration write data
    always_ff @(posedge SCLK) begin
        if (state == WRCAL_W_REQ) begin
            cal_l_datain <= WRCAL_WORD;
        end
    end

    req_exclusive: assert property (
        @(posedge SCLK) disable iff (!INIT_RESET_int)
        !(cal_l_r_req && cal_l_w_req)
    );

    training_after_init: assert property (
        @(posedge SCLK) disable iff (!INIT_RESET_int)
        dfi_training_complete |-> dfi_init_complete
    );

endmodule

`default_nettype wire

/* source/rden_phase_shift.sv */
//////////////////////////////////////////////////
// Read-enable history and phase realignment
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module rden_phase_shift (
    input  wire                                  SCLK,
    input  wire                                  INIT_RESET_int,
    input  wire  [ddr_lane_pkg::PHASES-1:0]      dfi_rddata_en,
    input  wire  [trn_seq_pkg::PHASE_SEL_W-1:0]  gate_phase_sel,
    output logic [ddr_lane_pkg::PHASES-1:0]      iog_rddata_en
);

    import ddr_lane_pkg::*;
    import trn_seq_pkg::*;

    logic [PHASES-1:0]   en_d1;
    logic [PHASES-1:0]   en_d2;
    logic [3*PHASES-1:0] en_stream;

    always_ff @(posedge SCLK or negedge INIT_RESET_int) begin
        if (!INIT_RESET_int) begin
            en_d1 <= '0;
            en_d2 <= '0;
        end else begin
            en_d1 <= dfi_rddata_en;
            en_d2 <= en_d1;
        end
    end

    // Oldest phase at bit 0, current cycle on top
    assign en_stream = {dfi_rddata_en, en_d1, en_d2};

    // Window slides back sel+1 phases from the current cycle
    assign iog_rddata_en = en_stream[(2*PHASES-1) - gate_phase_sel +: PHASES];

    // A select change with enables in flight would drop or repeat them
    enable_conserved: assert property (
        @(posedge SCLK) disable iff (!INIT_RESET_int)
        !$stable(gate_phase_sel) |-> (en_d1 == '0 && en_d2 == '0)
    );

endmodule

`default_nettype wire

/* source/trn_response_check.sv */
//////////////////////////////////////////////////
// Burst-detect qualification and read-back compare
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module trn_response_check (
    input  wire                              SCLK,
    input  wire                              INIT_RESET_int,
    input  wire  [ddr_lane_pkg::LANES-1:0]   burst_detect,
    input  wire  ddr_lane_pkg::cal_word_t    cal_l_dataout,
    output logic                             gate_good_burst,
    output logic                             wrcal_match
);

    import ddr_lane_pkg::*;

    // Newest sample in bit 0
    logic [2:0] burst_hist;

    always_ff @(posedge SCLK or negedge INIT_RESET_int) begin
        if (!INIT_RESET_int) begin
            burst_hist      <= '0;
            gate_good_burst <= 1'b0;
            wrcal_match     <= 1'b0;
        end else begin
            burst_hist <= {burst_hist[1:0], burst_detect[0]};
            // Only a lone single-cycle pulse counts
            gate_good_burst <= (burst_hist == 3'b010);
            wrcal_match     <= (cal_l_dataout == WRCAL_WORD);
        end
    end

    good_burst_single: assert property (
        @(posedge SCLK) disable iff (!INIT_RESET_int)
        gate_good_burst |=> !gate_good_burst
    );

endmodule

`default_nettype wire

/* source/ddr_training_top.sv */
//////////////////////////////////////////////////
// Training sequencer top, FSM plus read-enable
// shifter and response checker
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ddr_training_top (
    input  wire                                       SCLK,
    input  wire                                       INIT_RESET_int,
    input  wire  [trn_seq_pkg::VCOPHS_OFFSET_W-1:0]   addr_vcophs_offset,
    input  wire                                       ctrlr_ready_in,
    input  wire  [ddr_lane_pkg::PHASES-1:0]           dfi_rddata_en,
    input  wire  [ddr_lane_pkg::LANES-1:0]            burst_detect,
    input  wire                                       cal_l_d_req,
    input  wire                                       cal_l_busy,
    input  wire                                       cal_l_r_valid,
    input  wire  ddr_lane_pkg::cal_word_t             cal_l_dataout,
    output logic                                      loadphs_b,
    output logic                                      vco_phsel_bclk_sel,
    output logic                                      vco_phsel_bclk90_sel,
    output logic                                      vco_phsel_refclk_sel,
    output logic                                      vco_phsel_rotate,
    output logic [ddr_lane_pkg::LANES*ddr_lane_pkg::LANE_DLY_W-1:0] move,
    output logic [ddr_lane_pkg::LANES-1:0]            delay_line_sel_rd,
    output logic [ddr_lane_pkg::LANES-1:0]            init_pause,
    output logic                                      cmd_reset_lane,
    output logic                                      dfi_init_complete,
    output logic                                      dfi_training_complete,
    output logic                                      ctrlr_ready_out,
    output logic                                      cal_select,
    output logic                                      cal_l_r_req,
    output logic                                      cal_l_w_req,
    output ddr_lane_pkg::cal_word_t                   cal_l_datain,
    output logic [trn_seq_pkg::WRCAL_OFFSET_W-1:0]    write_cal_offset,
    output logic [ddr_lane_pkg::PHASES-1:0]           iog_rddata_en
);

    import trn_seq_pkg::*;

    wire [PHASE_SEL_W-1:0] gate_phase_sel;
    wire                   gate_good_burst;
    wire                   wrcal_match;

    trn_sequencer trn_sequencer_i (
        .SCLK                  (SCLK),
        .INIT_RESET_int        (INIT_RESET_int),
        .addr_vcophs_offset    (addr_vcophs_offset),
        .ctrlr_ready_in        (ctrlr_ready_in),
        .rden_p0_seen          (dfi_rddata_en[0]),
        .gate_good_burst       (gate_good_burst),
        .wrcal_match           (wrcal_match),
        .cal_l_d_req           (cal_l_d_req),
        .cal_l_busy            (cal_l_busy),
        .cal_l_r_valid         (cal_l_r_valid),
        .loadphs_b             (loadphs_b),
        .vco_phsel_bclk_sel    (vco_phsel_bclk_sel),
        .vco_phsel_bclk90_sel  (vco_phsel_bclk90_sel),
        .vco_phsel_refclk_sel  (vco_phsel_refclk_sel),
        .vco_phsel_rotate      (vco_phsel_rotate),
        .move                  (move),
        .delay_line_sel_rd     (delay_line_sel_rd),
        .init_pause            (init_pause),
        .cmd_reset_lane        (cmd_reset_lane),
        .dfi_init_complete     (dfi_init_complete),
        .dfi_training_complete (dfi_training_complete),
        .ctrlr_ready_out       (ctrlr_ready_out),
        .cal_select            (cal_select),
        .cal_l_r_req           (cal_l_r_req),
        .cal_l_w_req           (cal_l_w_req),
        .cal_l_datain          (cal_l_datain),
        .gate_phase_sel        (gate_phase_sel),
        .write_cal_offset      (write_cal_offset)
    );

    rden_phase_shift rden_phase_shift_i (
        .SCLK           (SCLK),
        .INIT_RESET_int (INIT_RESET_int),
        .dfi_rddata_en  (dfi_rddata_en),
        .gate_phase_sel (gate_phase_sel),
        .iog_rddata_en  (iog_rddata_en)
    );

    trn_response_check trn_response_check_i (
        .SCLK            (SCLK),
        .INIT_RESET_int  (INIT_RESET_int),
        .burst_detect    (burst_detect),
        .cal_l_dataout   (cal_l_dataout),
        .gate_good_burst (gate_good_burst),
        .wrcal_match     (wrcal_match)
    );

endmodule

`default_nettype wire

/* bench/tb_ctrlr_model.sv */
//////////////////////////////////////////////////
// Behavioral memory controller and burst-detect model
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_ctrlr_model (
    input  wire                                    SCLK,
    input  wire                                    INIT_RESET_int,
    input  wire                                    dfi_init_complete,
    input  wire                                    cal_l_r_req,
    input  wire                                    cal_l_w_req,
    input  wire  ddr_lane_pkg::cal_word_t          cal_l_datain,
    input  wire  [trn_seq_pkg::WRCAL_OFFSET_W-1:0] write_cal_offset,
    input  wire  [ddr_lane_pkg::PHASES-1:0]        iog_rddata_en,
    output logic                                   ctrlr_ready_in,
    output logic [ddr_lane_pkg::PHASES-1:0]        dfi_rddata_en,
    output logic [ddr_lane_pkg::LANES-1:0]         burst_detect,
    output logic                                   cal_l_d_req,
    output logic                                   cal_l_busy,
    output logic                                   cal_l_r_valid,
    output ddr_lane_pkg::cal_word_t                cal_l_dataout,
    output logic [trn_seq_pkg::PHASE_SEL_W-1:0]    target_sel,
    output logic [trn_seq_pkg::WRCAL_OFFSET_W-1:0] target_ofs
);

    import ddr_lane_pkg::*;
    import trn_seq_pkg::*;

    logic [31:0] lfsr_state = 32'ha737;
    cal_word_t   stored_word;
    logic        wrote;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic tick();
        @(posedge SCLK);
        #1;
    endtask

    task automatic random_latency(output int lat);
        int v;
        take_bits(2, v);
        lat = v + 1;
    endtask

    //////////////////////////////////////////////////
    // Gate read that bursts only at the target alignment
    //////////////////////////////////////////////////
    task automatic gate_read();
        int lat;
        int dly;
        logic hit;
        random_latency(lat);
        dly = int'(target_sel) + 1;
        hit = 1'b0;
        repeat (lat) tick();
        dfi_rddata_en = 4'b0001;
        for (int i = 0; i <= dly / PHASES; i++) begin
            if (i > 0) begin
                tick();
                dfi_rddata_en = '0;
            end
            @(negedge SCLK);
            if (i == dly / PHASES) begin
                hit = iog_rddata_en[dly % PHASES];
            end
        end
        tick();
        dfi_rddata_en = '0;
        if (hit) begin
            burst_detect = '1;
            tick();
            burst_detect = '0;
        end
    endtask

    task automatic cal_write();
        int lat;
        random_latency(lat);
        repeat (lat) tick();
        cal_l_d_req = 1'b1;
        cal_l_busy  = 1'b1;
        stored_word = (write_cal_offset == target_ofs) ? cal_l_datain : ~cal_l_datain;
        wrote = 1'b1;
        tick();
        cal_l_d_req = 1'b0;
        repeat (lat) tick();
        cal_l_busy = 1'b0;
    endtask

    task automatic cal_read();
        int lat;
        random_latency(lat);
        repeat (lat) tick();
        cal_l_r_valid = 1'b1;
        cal_l_dataout = stored_word;
        tick();
        cal_l_r_valid = 1'b0;
        cal_l_dataout = '0;
    endtask

    initial begin
        int v;
        ctrlr_ready_in = 1'b0;
        dfi_rddata_en  = '0;
        burst_detect   = '0;
        cal_l_d_req    = 1'b0;
        cal_l_busy     = 1'b0;
        cal_l_r_valid  = 1'b0;
        cal_l_dataout  = '0;
        stored_word    = '0;
        wrote          = 1'b0;
        take_bits(3, v);
        target_sel = v[2:0];
        take_bits(3, v);
        target_ofs = v[2:0];
        wait (INIT_RESET_int === 1'b1);
        wait (dfi_init_complete === 1'b1);
        take_bits(4, v);
        repeat (5 + v) tick();
        ctrlr_ready_in = 1'b1;
        forever begin
            @(negedge SCLK);
            if (cal_l_r_req && !wrote) begin
                gate_read();
            end else if (cal_l_w_req) begin
                cal_write();
            end else if (cal_l_r_req) begin
                cal_read();
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_ddr_training.sv */
//////////////////////////////////////////////////
// Training testbench with clock, reset, checks and report
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_ddr_training;

    import ddr_lane_pkg::*;
    import trn_seq_pkg::*;

    localparam int        CYCLE_LIMIT = 4000;
    localparam logic [2:0] VCO_OFS    = 3'd4;
    // Pattern bytes low first, each doubled for two lanes
    localparam logic [127:0] EXP_WORD = 128'h6666_4444_9999_FFFF_AAAA_CCCC_3333_5555;

    logic SCLK = 1'b0;
    logic INIT_RESET_int;
    logic [2:0] addr_vcophs_offset;
    wire ctrlr_ready_in, cal_l_d_req, cal_l_busy, cal_l_r_valid;
    wire [PHASES-1:0] dfi_rddata_en, iog_rddata_en;
    wire [LANES-1:0] burst_detect, delay_line_sel_rd, init_pause;
    wire cal_word_t cal_l_dataout, cal_l_datain;
    wire loadphs_b, vco_phsel_bclk_sel, vco_phsel_bclk90_sel, vco_phsel_refclk_sel;
    wire vco_phsel_rotate, cmd_reset_lane, dfi_init_complete, dfi_training_complete;
    wire ctrlr_ready_out, cal_select, cal_l_r_req, cal_l_w_req;
    wire [LANES*LANE_DLY_W-1:0] move;
    wire [2:0] write_cal_offset, target_sel, target_ofs;

    int errors = 0;
    int cycles = 0;
    logic timed_out = 1'b0;

    always #10 SCLK = ~SCLK;

    ddr_training_top ddr_training_top_i (.*);

    tb_ctrlr_model ctrlr_model_i (.*);

    //////////////////////////////////////////////////
    // Checks sampled on the falling edge
    //////////////////////////////////////////////////
    logic load_seen = 0, rst_seen = 0, step_move = 0, done_seen = 0, last_match = 0;
    logic prev_cal_sel = 0;
    int rot_cnt = 0, walk_cnt = 0, pause_cnt = 0, sel_model;
    logic [PHASES-1:0] h1 = '0, h2 = '0, exp_en;
    logic [3*PHASES-1:0] stream;

    always @(negedge SCLK) begin
        if (!load_seen) begin
            assert ({vco_phsel_bclk_sel, vco_phsel_bclk90_sel, vco_phsel_refclk_sel,
                     vco_phsel_rotate, move, init_pause, cmd_reset_lane, dfi_init_complete,
                     dfi_training_complete, ctrlr_ready_out, cal_select, cal_l_r_req,
                     cal_l_w_req} == '0 && delay_line_sel_rd == 2'b11)
            else begin
                errors++;
                $display("Control outputs not at reset values before loadphs_b at %0t", $time);
            end
            load_seen = INIT_RESET_int && loadphs_b;
        end
        // Rotation steps and select thresholds
        if (!rst_seen && move != '0) step_move = 1'b1;
        if (!rst_seen && vco_phsel_rotate) begin
            assert (vco_phsel_refclk_sel == (rot_cnt <= VCO_OFS + 1)) else begin
                errors++;
                $display("Error at %0t: vco_phsel_refclk_sel got %b expected %b", $time,
                         vco_phsel_refclk_sel, rot_cnt <= VCO_OFS + 1);
            end
            assert (vco_phsel_bclk90_sel == (rot_cnt <= 3)) else begin
                errors++;
                $display("Error at %0t: vco_phsel_bclk90_sel got %b expected %b", $time,
                         vco_phsel_bclk90_sel, rot_cnt <= 3);
            end
            assert (vco_phsel_bclk_sel == (rot_cnt <= 1)) else begin
                errors++;
                $display("Error at %0t: vco_phsel_bclk_sel got %b expected %b", $time,
                         vco_phsel_bclk_sel, rot_cnt <= 1);
            end
            assert (step_move == (rot_cnt <= 1)) else begin
                errors++;
                $display("Error at %0t: move pulse got %b expected %b", $time,
                         step_move, rot_cnt <= 1);
            end
            rot_cnt++;
            step_move = 1'b0;
        end
        if (cmd_reset_lane && !rst_seen) begin
            rst_seen = 1'b1;
            assert (rot_cnt == CLK_ROTATE_STEPS) else begin
                errors++;
                $display("Error at %0t: rotate count got %0d expected %0d", $time,
                         rot_cnt, CLK_ROTATE_STEPS);
            end
        end
        // Write walk
        assert (move[MOVE_BIT] == move[LANE_DLY_W + MOVE_BIT]) else begin
            errors++;
            $display("Move pulse not present on every lane at %0t", $time);
        end
        assert (!(dfi_init_complete && !ctrlr_ready_in && move != '0)) else begin
            errors++;
            $display("Move pulse while controller not ready at %0t", $time);
        end
        if (ctrlr_ready_in && !cal_select && move[MOVE_BIT]) walk_cnt++;
        if (cal_select && !prev_cal_sel && !done_seen) begin
            assert (walk_cnt == WRITE_MOVE_PULSES) else begin
                errors++;
                $display("Error at %0t: move pulses got %0d expected %0d", $time,
                         walk_cnt, WRITE_MOVE_PULSES);
            end
        end
        prev_cal_sel = cal_select;
        // First pause opens the gate search and leaves sel alone
        if (init_pause[0]) pause_cnt++;
        sel_model = 7 - ((pause_cnt > 0) ? pause_cnt - 1 : 0);
        stream = {dfi_rddata_en, h1, h2};
        for (int j = 0; j < PHASES; j++) begin
            exp_en[j] = stream[2*PHASES + j - (sel_model + 1)];
        end
        assert (iog_rddata_en == exp_en) else begin
            errors++;
            $display("Error at %0t: iog_rddata_en got %b expected %b", $time,
                     iog_rddata_en, exp_en);
        end
        h2 = h1;
        h1 = dfi_rddata_en;
        // Write calibration
        if (cal_l_w_req || cal_l_d_req) begin
            assert (cal_l_datain == EXP_WORD) else begin
                errors++;
                $display("Error at %0t: cal_l_datain got %h expected %h", $time,
                         cal_l_datain, EXP_WORD);
            end
        end
        if (cal_l_r_valid) last_match = (cal_l_dataout == EXP_WORD);
        assert (dfi_training_complete == ctrlr_ready_out) else begin
            errors++;
            $display("Error at %0t: ctrlr_ready_out got %b expected %b", $time,
                     ctrlr_ready_out, dfi_training_complete);
        end
        if (done_seen) begin
            assert (dfi_training_complete && !cal_select) else begin
                errors++;
                $display("Completion outputs changed after training at %0t", $time);
            end
        end else if (dfi_training_complete) begin
            done_seen = 1'b1;
            assert (!cal_select) else begin
                errors++;
                $display("Error at %0t: cal_select got %b expected 0", $time, cal_select);
            end
            assert (last_match && sel_model == target_sel && write_cal_offset == target_ofs)
            else begin
                errors++;
                $display("Error at %0t: sel/offset got %0d/%0d expected %0d/%0d", $time,
                         sel_model, write_cal_offset, target_sel, target_ofs);
            end
        end
    end

    initial begin
        INIT_RESET_int     = 1'b0;
        addr_vcophs_offset = VCO_OFS;
        repeat (10) @(posedge SCLK);
        #1 INIT_RESET_int = 1'b1;
        while (!done_seen && cycles < CYCLE_LIMIT) begin
            @(posedge SCLK);
            cycles++;
        end
        if (!done_seen) begin
            timed_out = 1'b1;
            $display("Timeout: training not complete after %0d cycles", CYCLE_LIMIT);
        end
        repeat (20) @(negedge SCLK);
        $display("Errors: %0d, timeouts: %0d", errors, int'(timed_out));
        if (errors == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/ddr_lane_pkg.sv
source/trn_seq_pkg.sv
source/trn_sequencer.sv
source/rden_phase_shift.sv
source/trn_response_check.sv
source/ddr_training_top.sv
bench/tb_ctrlr_model.sv
bench/tb_ddr_training.sv

/* Makefile */
# Verilator build and run for the training sequencer testbench

TOP = tb_ddr_training

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
